/* files.f */
logic/pad_mode_pkg.sv
logic/sync_2ff.sv
logic/debug_port_router.sv
logic/imem_load_shifter.sv
logic/imem_record_fifo.sv
logic/imem_axil_writer.sv
logic/pad_ring_ctrl.sv
testbench/pad_ring_ctrl_props.sv
testbench/pad_ring_ctrl_tb.sv

/* logic/debug_port_router.sv */
`timescale 1ns/1ps

module debug_port_router import pad_mode_pkg::*; (
	input  mode_t                 mode_sel,
	input  logic [port_width-1:0] port_a_in,
	input  logic [port_width-1:0] port_b_in,
	input  logic                  sout_low,
	input  logic                  sout_high,
	input  logic [port_width-1:0] core_outputs,
	output serial_port_t          serial_low,
	output serial_port_t          serial_high,
	output logic [port_width-1:0] port_b_out,
	output logic                  port_b_lsb_oe,
	output logic                  reset_pat,
	output logic                  reset_patternbuf_low,
	output logic                  reset_patternbuf_high,
	output load_in_t              load_in
);

	logic         is_debug;
	logic         is_hold;
	logic         buf_sel;
	logic         sout_sel;
	serial_port_t dbg_bus;

	assign is_debug = (mode_sel == mode_debug);
	// Reset and memory load both keep everything in reset
	assign is_hold = (mode_sel == mode_reset) || (mode_sel == mode_memload);

	// 0 selects the low pattern buffer, 1 the high one
	assign buf_sel = port_a_in[buf_sel_bit];

	always_comb begin
		dbg_bus.sclk  = port_a_in[sclk_bit];
		dbg_bus.ssel  = port_a_in[ssel_bit];
		dbg_bus.sin   = port_a_in[sin_bit];
		dbg_bus.saddr = port_a_in[saddr_lsb +: saddr_width];
	end

	assign serial_low  = (is_debug && !buf_sel) ? dbg_bus : '0;
	assign serial_high = (is_debug && buf_sel) ? dbg_bus : '0;

	assign sout_sel = buf_sel ? sout_high : sout_low;

	always_comb begin
		port_b_out = core_outputs;
		if (is_debug) begin
			port_b_out = core_outputs | pullup_mask;
			port_b_out[sout_bit] = sout_sel;
		end
	end

	// Lower nibble only drives in run mode, upper nibble always drives
	assign port_b_lsb_oe = (mode_sel == mode_run);

	assign reset_pat = is_hold || (is_debug && port_b_in[reset_pat_bit]);
	assign reset_patternbuf_low = is_hold || (is_debug && port_b_in[reset_buf_low_bit]);
	assign reset_patternbuf_high = is_hold || (is_debug && port_b_in[reset_buf_high_bit]);

	always_comb begin
		load_in = '0;
		if (mode_sel == mode_memload) begin
			load_in.load_byte  = port_a_in;
			load_in.load_clk   = port_b_in[load_clk_bit];
			load_in.load_write = port_b_in[load_write_bit];
		end
	end

endmodule

/* logic/imem_axil_writer.sv */
`timescale 1ns/1ps

module imem_axil_writer import pad_mode_pkg::*; (
	input  logic                       clk_int,
	input  logic                       mode_is_reset,
	input  logic                       record_valid,
	input  imem_record_t               record_out,
	output logic                       record_pop,
	output logic                       awvalid,
	input  logic                       awready,
	output logic [imem_addr_width-1:0] awaddr,
	output logic                       wvalid,
	input  logic                       wready,
	output logic [imem_data_width-1:0] wdata,
	input  logic                       bvalid,
	output logic                       bready
);

	typedef enum logic [1:0] {
		st_idle,
		st_addr_data,
		st_resp
	} state_t;

	state_t state;
	logic   aw_done;
	logic   w_done;
	logic   aw_fire;
	logic   w_fire;

	// FIFO head stays put until the pop, so it feeds the bus directly
	assign awaddr = record_out.addr;
	assign wdata = record_out.data;

	assign awvalid = (state == st_addr_data) && !aw_done;
	assign wvalid = (state == st_addr_data) && !w_done;
	assign bready = (state == st_resp);

	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;

	// Record leaves the FIFO on the write response
	assign record_pop = bready && bvalid;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			state   <= st_idle;
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (record_valid) state <= st_addr_data;
				end
				st_addr_data: begin
					if (aw_fire) aw_done <= 1'b1;
					if (w_fire) w_done <= 1'b1;
					// Channels may be accepted in either order or together
					if ((aw_done || aw_fire) && (w_done || w_fire)) begin
						state   <= st_resp;
						aw_done <= 1'b0;
						w_done  <= 1'b0;
					end
				end
				st_resp: begin
					if (bvalid) state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

/* logic/imem_load_shifter.sv */
`timescale 1ns/1ps

module imem_load_shifter import pad_mode_pkg::*; (
	input  logic         clk_int,
	input  logic         mode_is_reset,
	input  load_in_t     load_sync,
	output logic         record_push,
	output imem_record_t record_in
);

	logic [shifter_width-1:0] shift_reg;
	logic                     clk_prev;
	logic                     write_prev;
	logic                     clk_rise;
	logic                     write_rise;

	// Strobes are already synchronized, edges found against last cycle
	assign clk_rise = load_sync.load_clk && !clk_prev;
	assign write_rise = load_sync.load_write && !write_prev;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			shift_reg  <= '0;
			clk_prev   <= 1'b0;
			write_prev <= 1'b0;
		end else begin
			clk_prev   <= load_sync.load_clk;
			write_prev <= load_sync.load_write;
			// New byte enters at the bottom, oldest bits fall off the top
			if (clk_rise) begin
				shift_reg <= {shift_reg[shifter_width-port_width-1:0], load_sync.load_byte};
			end
		end
	end

	// One record per write strobe, taken from the current shifter contents
	assign record_push = write_rise;

	// Two 24-bit patterns arrive, the memory only keeps 23 bits of each
	assign record_in = '{
		addr: shift_reg[shifter_width-1 -: imem_addr_width],
		data: {shift_reg[2*pattern_width-2 -: pattern_width-1],
		       shift_reg[pattern_width-2:0]}
	};

endmodule

/* logic/imem_record_fifo.sv */
`timescale 1ns/1ps

module imem_record_fifo import pad_mode_pkg::*; (
	input  logic         clk_int,
	input  logic         mode_is_reset,
	input  logic         record_push,
	input  imem_record_t record_in,
	input  logic         record_pop,
	output logic         record_valid,
	output imem_record_t record_out,
	output logic         load_overflow
);

	typedef logic [$clog2(fifo_depth)-1:0] ptr_t;
	typedef logic [$clog2(fifo_depth+1)-1:0] count_t;

	imem_record_t mem [fifo_depth];
	ptr_t         wr_ptr;
	ptr_t         rd_ptr;
	count_t       count;
	logic         full;
	logic         do_push;
	logic         do_pop;

	function automatic ptr_t next_ptr(input ptr_t p);
		return (p == ptr_t'(fifo_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full = (count == count_t'(fifo_depth));
	assign record_valid = (count != '0);
	assign record_out = mem[rd_ptr];

	// A push into a full FIFO is lost
	assign do_push = record_push && !full;
	assign do_pop = record_pop && record_valid;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			load_overflow <= 1'b0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (do_pop) rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
			// Sticky until the next reset
			if (record_push && full) load_overflow <= 1'b1;
		end
	end

	always_ff @(posedge clk_int) begin
		if (do_push) mem[wr_ptr] <= record_in;
	end

endmodule

/* logic/pad_mode_pkg.sv */
package pad_mode_pkg;

	// Operating modes decoded from the two mode select pins
	typedef enum logic [1:0] {
		mode_reset   = 2'd0,
		mode_debug   = 2'd1,
		mode_run     = 2'd2,
		mode_memload = 2'd3
	} mode_t;

	localparam int port_width = 8;
	localparam int saddr_width = 3;

	// Instruction memory record geometry
	localparam int imem_addr_width = 10;
	localparam int imem_data_width = 46;
	localparam int pattern_width = 24;
	localparam int shifter_width = 58;
	localparam int fifo_depth = 4;

	// Port A bits used by the serial debug bus
	localparam int sclk_bit = 0;
	localparam int ssel_bit = 1;
	localparam int sin_bit = 2;
	localparam int saddr_lsb = 3;
	localparam int buf_sel_bit = 6;

	// Port B inputs and outputs share the lower nibble
	localparam int load_clk_bit = 0;
	localparam int load_write_bit = 1;
	localparam int reset_buf_low_bit = 0;
	localparam int reset_buf_high_bit = 1;
	localparam int reset_pat_bit = 2;
	localparam int sout_bit = 4;

	// Reset request pins float high in debug mode
	localparam logic [port_width-1:0] pullup_mask = 8'h0F;

	typedef struct packed {
		logic                   sclk;
		logic                   ssel;
		logic                   sin;
		logic [saddr_width-1:0] saddr;
	} serial_port_t;

	typedef struct packed {
		logic [port_width-1:0] load_byte;
		logic                  load_clk;
		logic                  load_write;
	} load_in_t;

	typedef struct packed {
		logic pwm_low;
		logic pwm_high;
	} pwm_t;

	typedef struct packed {
		logic [imem_addr_width-1:0] addr;
		logic [imem_data_width-1:0] data;
	} imem_record_t;

endpackage

/* logic/pad_ring_ctrl.sv */
`timescale 1ns/1ps

module pad_ring_ctrl import pad_mode_pkg::*; (
	input  logic                       clk_int,
	input  logic                       mode_is_reset,
	input  mode_t                      mode_sel,
	input  logic [port_width-1:0]      port_a_in,
	input  logic [port_width-1:0]      port_b_in,
	output logic [port_width-1:0]      port_b_out,
	output logic                       port_b_lsb_oe,
	input  logic                       sout_low,
	input  logic                       sout_high,
	input  logic [port_width-1:0]      core_outputs,
	input  pwm_t                       pwm_in,
	output pwm_t                       pwm_sync,
	output serial_port_t               serial_low,
	output serial_port_t               serial_high,
	output logic                       reset_pat,
	output logic                       reset_patternbuf_low,
	output logic                       reset_patternbuf_high,
	output logic                       awvalid,
	input  logic                       awready,
	output logic [imem_addr_width-1:0] awaddr,
	output logic                       wvalid,
	input  logic                       wready,
	output logic [imem_data_width-1:0] wdata,
	input  logic                       bvalid,
	output logic                       bready,
	output logic                       load_overflow
);

	load_in_t     load_in;
	load_in_t     load_sync;
	logic         record_push;
	imem_record_t record_in;
	logic         record_pop;
	logic         record_valid;
	imem_record_t record_out;

	debug_port_router router_i (
		.mode_sel              (mode_sel),
		.port_a_in             (port_a_in),
		.port_b_in             (port_b_in),
		.sout_low              (sout_low),
		.sout_high             (sout_high),
		.core_outputs          (core_outputs),
		.serial_low            (serial_low),
		.serial_high           (serial_high),
		.port_b_out            (port_b_out),
		.port_b_lsb_oe         (port_b_lsb_oe),
		.reset_pat             (reset_pat),
		.reset_patternbuf_low  (reset_patternbuf_low),
		.reset_patternbuf_high (reset_patternbuf_high),
		.load_in               (load_in)
	);

	// Load pins change on a slow external strobe
	sync_2ff #(.payload_t(load_in_t)) load_sync_i (
		.clk_int       (clk_int),
		.mode_is_reset (mode_is_reset),
		.async_in      (load_in),
		.sync_out      (load_sync)
	);

	sync_2ff #(.payload_t(pwm_t)) pwm_sync_i (
		.clk_int       (clk_int),
		.mode_is_reset (mode_is_reset),
		.async_in      (pwm_in),
		.sync_out      (pwm_sync)
	);

	imem_load_shifter shifter_i (
		.clk_int       (clk_int),
		.mode_is_reset (mode_is_reset),
		.load_sync     (load_sync),
		.record_push   (record_push),
		.record_in     (record_in)
	);

	imem_record_fifo fifo_i (
		.clk_int       (clk_int),
		.mode_is_reset (mode_is_reset),
		.record_push   (record_push),
		.record_in     (record_in),
		.record_pop    (record_pop),
		.record_valid  (record_valid),
		.record_out    (record_out),
		.load_overflow (load_overflow)
	);

	imem_axil_writer writer_i (
		.clk_int       (clk_int),
		.mode_is_reset (mode_is_reset),
		.record_valid  (record_valid),
		.record_out    (record_out),
		.record_pop    (record_pop),
		.awvalid       (awvalid),
		.awready       (awready),
		.awaddr        (awaddr),
		.wvalid        (wvalid),
		.wready        (wready),
		.wdata         (wdata),
		.bvalid        (bvalid),
		.bready        (bready)
	);

endmodule

/* logic/sync_2ff.sv */
`timescale 1ns/1ps

module sync_2ff #(
	parameter type payload_t = logic
) (
	input  logic     clk_int,
	input  logic     mode_is_reset,
	input  payload_t async_in,
	output payload_t sync_out
);

	// First stage may go metastable, second stage feeds the logic
	payload_t meta_q;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			meta_q   <= '0;
			sync_out <= '0;
		end else begin
			meta_q   <= async_in;
			sync_out <= meta_q;
		end
	end

endmodule

/* testbench/pad_ring_ctrl_props.sv */
`timescale 1ns/1ps

module pad_ring_ctrl_props import pad_mode_pkg::*; (
	input logic                       clk_int,
	input logic                       mode_is_reset,
	input mode_t                      mode_sel,
	input serial_port_t               serial_low,
	input serial_port_t               serial_high,
	input logic                       awvalid,
	input logic                       awready,
	input logic [imem_addr_width-1:0] awaddr,
	input logic                       wvalid,
	input logic                       wready,
	input logic [imem_data_width-1:0] wdata,
	input logic                       bvalid,
	input logic                       bready
);

	int unsigned fail_count = 0;
	logic        aw_seen;
	logic        w_seen;

	// Which channels of the current write have been accepted so far
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			aw_seen <= 1'b0;
			w_seen  <= 1'b0;
		end else if (bvalid && bready) begin
			aw_seen <= 1'b0;
			w_seen  <= 1'b0;
		end else begin
			if (awvalid && awready) aw_seen <= 1'b1;
			if (wvalid && wready) w_seen <= 1'b1;
		end
	end

	aw_hold: assert property (@(posedge clk_int) disable iff (mode_is_reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin $error("awvalid or awaddr changed before acceptance"); fail_count++; end

	w_hold: assert property (@(posedge clk_int) disable iff (mode_is_reset)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin $error("wvalid or wdata changed before acceptance"); fail_count++; end

	b_order: assert property (@(posedge clk_int) disable iff (mode_is_reset)
		bready |-> aw_seen && w_seen)
		else begin $error("bready high before both channels were accepted"); fail_count++; end

	// Serial buses only carry traffic in debug mode
	bus_idle: assert property (@(posedge clk_int) disable iff (mode_is_reset)
		mode_sel != mode_debug |-> serial_low == '0 && serial_high == '0)
		else begin $error("serial bus active outside debug mode"); fail_count++; end

	reset_quiet: assert property (@(posedge clk_int)
		mode_is_reset |-> !awvalid && !wvalid && !bready)
		else begin $error("AXI handshake active during reset"); fail_count++; end

endmodule

bind pad_ring_ctrl pad_ring_ctrl_props props_i (
	.clk_int       (clk_int),
	.mode_is_reset (mode_is_reset),
	.mode_sel      (mode_sel),
	.serial_low    (serial_low),
	.serial_high   (serial_high),
	.awvalid       (awvalid),
	.awready       (awready),
	.awaddr        (awaddr),
	.wvalid        (wvalid),
	.wready        (wready),
	.wdata         (wdata),
	.bvalid        (bvalid),
	.bready        (bready)
);

/* testbench/pad_ring_ctrl_tb.sv */
`timescale 1ns/1ps

module pad_ring_ctrl_tb import pad_mode_pkg::*; ();

	logic                       clk_int;
	logic                       mode_is_reset;
	mode_t                      mode_sel;
	logic [port_width-1:0]      port_a_in;
	logic [port_width-1:0]      port_b_in;
	logic [port_width-1:0]      port_b_out;
	logic                       port_b_lsb_oe;
	logic                       sout_low;
	logic                       sout_high;
	logic [port_width-1:0]      core_outputs;
	pwm_t                       pwm_in;
	pwm_t                       pwm_sync;
	serial_port_t               serial_low;
	serial_port_t               serial_high;
	logic                       reset_pat;
	logic                       reset_patternbuf_low;
	logic                       reset_patternbuf_high;
	logic                       awvalid;
	logic                       awready;
	logic [imem_addr_width-1:0] awaddr;
	logic                       wvalid;
	logic                       wready;
	logic [imem_data_width-1:0] wdata;
	logic                       bvalid;
	logic                       bready;
	logic                       load_overflow;

	logic [31:0]                rng;
	logic [31:0]                resp_rng;
	logic [31:0]                ready_rng;
	logic                       stall;
	logic                       aw_got;
	logic                       w_got;
	logic [1:0]                 resp_delay;
	logic [imem_addr_width-1:0] got_addr;
	logic [imem_data_width-1:0] got_data;
	logic [shifter_width-1:0]   model_sh;
	logic [55:0]                expected_q [$];
	logic [55:0]                write_q [$];
	int                         error_count;
	int                         check_count;
	int                         test_count;
	int                         errs_before;

	pad_ring_ctrl dut_i (.*);

	initial begin
		clk_int = 1'b0;
		forever #20 clk_int = ~clk_int;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic random_byte(output logic [7:0] b);
		rng = xorshift32(rng);
		b = rng[7:0];
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count++;
		assert (got === exp) else begin
			$display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name);
		test_count++;
		$display("%s finished with %0d errors", name, error_count - errs_before);
	endtask

	task automatic wait_writes(input int n, input int limit);
		int cycles;
		cycles = 0;
		while (write_q.size() < n) begin
			@(posedge clk_int);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout: %0d of %0d AXI writes arrived", write_q.size(), n);
				$display("Test FAILED");
				$finish;
			end
		end
	endtask

	// AXI4-Lite slave with random ready gaps and a random response delay
	always @(posedge clk_int) begin
		if (mode_is_reset) begin
			awready    <= 1'b0;
			wready     <= 1'b0;
			bvalid     <= 1'b0;
			aw_got     <= 1'b0;
			w_got      <= 1'b0;
			resp_delay <= 2'd0;
		end else begin
			ready_rng = xorshift32(ready_rng);
			// Independent gaps let the two channels be accepted in either order
			awready <= !stall && ready_rng[0];
			wready  <= !stall && ready_rng[1];
			if (awvalid && awready) begin
				aw_got   <= 1'b1;
				got_addr <= awaddr;
			end
			if (wvalid && wready) begin
				w_got    <= 1'b1;
				got_data <= wdata;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
				write_q.push_back({got_addr, got_data});
			end else if (aw_got && w_got && !bvalid) begin
				if (resp_delay == 2'd0) begin
					bvalid <= 1'b1;
					resp_rng = xorshift32(resp_rng);
					resp_delay <= resp_rng[1:0];
				end else begin
					resp_delay <= resp_delay - 1'b1;
				end
			end
		end
	end

	task automatic test_debug_routing();
		logic [7:0]   a;
		mode_t        m;
		serial_port_t exp_bus;
		errs_before = error_count;
		for (int i = 0; i < 24; i++) begin
			random_byte(a);
			// Low buffer then high buffer, then the three quiet modes
			if (i < 12) begin
				m = mode_debug;
				a[buf_sel_bit] = (i >= 6);
			end else begin
				m = mode_t'((i % 3 == 0) ? 0 : (i % 3) + 1);
			end
			exp_bus = {a[sclk_bit], a[ssel_bit], a[sin_bit], a[saddr_lsb +: 3]};
			@(posedge clk_int);
			mode_sel  <= m;
			port_a_in <= a;
			@(negedge clk_int);
			check_value("serial_low", serial_low,
				(m == mode_debug && !a[buf_sel_bit]) ? exp_bus : 6'h0);
			check_value("serial_high", serial_high,
				(m == mode_debug && a[buf_sel_bit]) ? exp_bus : 6'h0);
		end
		report_test("debug routing");
	endtask

	task automatic test_port_b();
		logic [7:0] a;
		logic [7:0] core;
		logic [7:0] s;
		logic [7:0] exp;
		mode_t      m;
		errs_before = error_count;
		for (int i = 0; i < 16; i++) begin
			random_byte(a);
			random_byte(core);
			random_byte(s);
			m = (i < 8) ? mode_debug : mode_t'(i % 4);
			exp = core;
			if (m == mode_debug) begin
				exp = core | pullup_mask;
				exp[sout_bit] = a[buf_sel_bit] ? s[1] : s[0];
			end
			@(posedge clk_int);
			mode_sel     <= m;
			port_a_in    <= a;
			core_outputs <= core;
			sout_low     <= s[0];
			sout_high    <= s[1];
			@(negedge clk_int);
			check_value("port_b_out", port_b_out, exp);
			check_value("port_b_lsb_oe", port_b_lsb_oe, m == mode_run);
		end
		report_test("port B drive");
	endtask

	task automatic test_reset_outputs();
		logic [2:0] pb;
		logic       hold;
		logic       dbg;
		mode_t      m;
		errs_before = error_count;
		for (int i = 0; i < 32; i++) begin
			m = mode_t'(i / 8);
			pb = i % 8;
			hold = (m == mode_reset) || (m == mode_memload);
			dbg = (m == mode_debug);
			@(posedge clk_int);
			mode_sel  <= m;
			port_b_in <= {5'b0, pb};
			@(negedge clk_int);
			check_value("reset_pat", reset_pat, hold || (dbg && pb[2]));
			check_value("reset_patternbuf_low", reset_patternbuf_low, hold || (dbg && pb[0]));
			check_value("reset_patternbuf_high", reset_patternbuf_high, hold || (dbg && pb[1]));
		end
		report_test("reset outputs");
	endtask

	// Clears the strobe traffic that the reset test pushed into the pipeline
	task automatic pulse_reset();
		@(posedge clk_int);
		mode_is_reset <= 1'b1;
		mode_sel      <= mode_reset;
		port_b_in     <= '0;
		repeat (2) @(posedge clk_int);
		mode_is_reset <= 1'b0;
		write_q.delete();
		expected_q.delete();
		model_sh = '0;
	endtask

	// Strobe held high and low long enough to survive the synchronizer
	task automatic strobe(input int bit_pos);
		@(posedge clk_int);
		port_b_in[bit_pos] <= 1'b1;
		repeat (4) @(posedge clk_int);
		port_b_in[bit_pos] <= 1'b0;
		repeat (3) @(posedge clk_int);
	endtask

	task automatic shift_byte(input logic [7:0] b);
		@(posedge clk_int);
		port_a_in <= b;
		strobe(load_clk_bit);
		model_sh = {model_sh[shifter_width-9:0], b};
	endtask

	task automatic write_record();
		strobe(load_write_bit);
		// Address on top, then two patterns with their top bits dropped
		expected_q.push_back({model_sh[57:48], model_sh[46:24], model_sh[22:0]});
	endtask

	task automatic compare_writes(input int n);
		logic [55:0] got;
		logic [55:0] exp;
		for (int i = 0; i < n; i++) begin
			got = write_q.pop_front();
			exp = expected_q.pop_front();
			check_value("awaddr", got[55:46], exp[55:46]);
			check_value("wdata", got[45:0], exp[45:0]);
		end
	endtask

	task automatic test_memory_load();
		int         lens [4] = '{8, 3, 5, 8};
		logic [7:0] b;
		errs_before = error_count;
		@(posedge clk_int);
		mode_sel <= mode_memload;
		for (int r = 0; r < 4; r++) begin
			for (int k = 0; k < lens[r]; k++) begin
				random_byte(b);
				shift_byte(b);
			end
			write_record();
		end
		wait_writes(4, 200);
		compare_writes(4);
		@(negedge clk_int);
		check_value("load_overflow", load_overflow, 1'b0);
		report_test("memory load");
	endtask

	task automatic test_back_pressure();
		logic [7:0] b;
		errs_before = error_count;
		@(posedge clk_int);
		stall <= 1'b1;
		for (int r = 0; r < 6; r++) begin
			random_byte(b);
			shift_byte(b);
			write_record();
		end
		@(negedge clk_int);
		check_value("load_overflow", load_overflow, 1'b1);
		check_value("write count", write_q.size(), 0);
		@(posedge clk_int);
		stall <= 1'b0;
		wait_writes(fifo_depth, 200);
		repeat (40) @(posedge clk_int);
		check_value("write count", write_q.size(), fifo_depth);
		compare_writes(fifo_depth);
		expected_q.delete();
		report_test("back-pressure");
	endtask

	task automatic test_pwm_sync();
		pwm_t       hist [16];
		logic [7:0] b;
		errs_before = error_count;
		for (int i = 0; i < 16; i++) begin
			random_byte(b);
			hist[i] = b[1:0];
			@(posedge clk_int);
			pwm_in <= hist[i];
			@(negedge clk_int);
			if (i >= 2) check_value("pwm_sync", pwm_sync, hist[i-2]);
		end
		report_test("PWM sync");
	endtask

	initial begin
		mode_is_reset <= 1'b1;
		mode_sel      = mode_reset;
		port_a_in     = '0;
		port_b_in     = '0;
		sout_low      = 1'b0;
		sout_high     = 1'b0;
		core_outputs  = '0;
		pwm_in        = '0;
		awready       = 1'b0;
		wready        = 1'b0;
		bvalid        = 1'b0;
		stall         = 1'b0;
		rng           = 32'd82;
		resp_rng      = 32'd82;
		ready_rng     = 32'd82;
		model_sh      = '0;
		error_count   = 0;
		check_count   = 0;
		test_count    = 0;
		repeat (2) @(posedge clk_int);
		mode_is_reset <= 1'b0;
		test_debug_routing();
		test_port_b();
		test_reset_outputs();
		pulse_reset();
		test_memory_load();
		test_back_pressure();
		test_pwm_sync();
		$display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
			test_count, check_count, error_count, dut_i.props_i.fail_count);
		if (error_count == 0 && dut_i.props_i.fail_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
